//--- sysele_pkg.sv
// Shared widths, bounds and types; word layout and DIP codes must match the vector file
package sysele_pkg;

   // --------------------------------------------------
   // Widths
   // --------------------------------------------------
   localparam int CODE_W         = 6;
   localparam int PAIRS_PER_WORD = 4;
   // Pair 0 in the low 12 bits, DA1 low half of each pair
   localparam int WORD_W         = 2 * CODE_W * PAIRS_PER_WORD;
   localparam int ADDR_W         = 6;

   // Playback region, wraps from top to bottom
   localparam logic [ADDR_W-1:0] REGION_BOTTOM = 6'd0;
   localparam logic [ADDR_W-1:0] REGION_TOP    = 6'd63;

   // Buffer between reader and unpacker
   localparam int FIFO_DEPTH = 8;
   localparam int LEVEL_W    = 4;

   // --------------------------------------------------
   // Bundles
   // --------------------------------------------------
   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      logic [WORD_W-1:0] data;
   } mem_wr_t;

   typedef struct packed {
      logic              valid;
      logic              flush;
      logic [WORD_W-1:0] data;
   } fifo_push_t;

   typedef struct packed {
      logic [CODE_W-1:0] da1;
      logic [CODE_W-1:0] da2;
   } dac_pair_t;

   // --------------------------------------------------
   // States and opcodes
   // --------------------------------------------------
   typedef enum logic {
      RD_IDLE = 1'b0,
      RD_RUN  = 1'b1
   } reader_state_e;

   typedef enum logic {
      PL_IDLE = 1'b0,
      PL_PLAY = 1'b1
   } player_state_e;

   // Any other DIP value shows zero
   typedef enum logic [7:0] {
      LED_DA1 = 8'd131,
      LED_DA2 = 8'd132
   } led_sel_e;

endpackage

//--- sample_reader.sv
// Writes through load_i take effect at any time; a word rewritten during playback may replay old or new
`timescale 1ns/1ps

module sample_reader (
   input  logic                             clkcomm_i,
   input  logic                             rst_i,
   input  sysele_pkg::mem_wr_t              load_i,
   input  logic                             start_i,
   input  logic                             stop_i,
   input  logic [sysele_pkg::LEVEL_W-1:0]   level_i,
   output sysele_pkg::fifo_push_t           push_o
);

   logic [sysele_pkg::WORD_W-1:0] mem [0:sysele_pkg::REGION_TOP];
   logic [sysele_pkg::WORD_W-1:0] rd_data;
   logic [sysele_pkg::ADDR_W-1:0] rd_addr;
   logic                          rd_issue;
   logic                          rd_pending;
   // Reads issued but not yet visible in level_i
   logic [1:0]                    inflight;
   logic [sysele_pkg::LEVEL_W:0]  committed;
   logic                          flush_q;
   sysele_pkg::reader_state_e     state;

   // --------------------------------------------------
   // Sample memory
   // --------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (load_i.en) begin
         mem[load_i.addr] <= load_i.data;
      end
      if (rd_issue) begin
         rd_data <= mem[rd_addr];
      end
   end

   // --------------------------------------------------
   // Read issue under the space rule
   // --------------------------------------------------
   assign committed = {1'b0, level_i} + {{(sysele_pkg::LEVEL_W - 1){1'b0}}, inflight};

   // No read in the cycle of a start or stop, the pipe is being cleared
   assign rd_issue = (state == sysele_pkg::RD_RUN) && !start_i && !stop_i &&
                     (committed < sysele_pkg::FIFO_DEPTH);

   always_ff @(posedge clkcomm_i) begin
      if (rst_i) begin
         state      <= sysele_pkg::RD_IDLE;
         rd_addr    <= sysele_pkg::REGION_BOTTOM;
         rd_pending <= 1'b0;
         inflight   <= 2'd0;
         flush_q    <= 1'b0;
      end else begin
         flush_q    <= start_i | stop_i;
         rd_pending <= rd_issue;
         if (stop_i) begin
            state    <= sysele_pkg::RD_IDLE;
            rd_addr  <= sysele_pkg::REGION_BOTTOM;
            inflight <= 2'd0;
         end else if (start_i) begin
            // Restart from the bottom, also when already running
            state    <= sysele_pkg::RD_RUN;
            rd_addr  <= sysele_pkg::REGION_BOTTOM;
            inflight <= 2'd0;
         end else begin
            inflight <= inflight + 2'(rd_issue) - 2'(rd_pending);
            if (rd_issue) begin
               if (rd_addr == sysele_pkg::REGION_TOP) begin
                  rd_addr <= sysele_pkg::REGION_BOTTOM;
               end else begin
                  rd_addr <= rd_addr + 1'b1;
               end
            end
         end
      end
   end

   // Data arrives one cycle after its address
   assign push_o.valid = rd_pending;
   assign push_o.flush = flush_q;
   assign push_o.data  = rd_data;

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   // Level comes back from the FIFO one cycle behind each push
   a_no_push_at_full: assert property (
      @(posedge clkcomm_i) disable iff (rst_i)
      push_o.valid |-> (level_i != sysele_pkg::FIFO_DEPTH)
   );

endmodule

//--- sample_fifo.sv
// First-word-fall-through buffer; the writer must respect level_o, a push at full is not absorbed
`timescale 1ns/1ps

module sample_fifo (
   input  logic                            clkcomm_i,
   input  logic                            rst_i,
   input  sysele_pkg::fifo_push_t          push_i,
   input  logic                            pop_i,
   output logic [sysele_pkg::WORD_W-1:0]   rd_data_o,
   output logic                            empty_o,
   output logic [sysele_pkg::LEVEL_W-1:0]  level_o
);

   logic [sysele_pkg::WORD_W-1:0]               mem [sysele_pkg::FIFO_DEPTH];
   logic [$clog2(sysele_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(sysele_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
   logic [sysele_pkg::LEVEL_W-1:0]              level;
   logic                                        do_push;
   logic                                        do_pop;

   // Flush wins over push and pop
   assign do_push = push_i.valid && !push_i.flush;
   assign do_pop  = pop_i && !push_i.flush && (level != '0);

   always_ff @(posedge clkcomm_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_i.data;
      end
   end

   // --------------------------------------------------
   // Pointers and level
   // --------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (rst_i || push_i.flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         // Depth is a power of two, pointers wrap naturally
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   assign rd_data_o = mem[rd_ptr];
   assign empty_o   = (level == '0);
   assign level_o   = level;

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_no_pop_empty: assert property (
      @(posedge clkcomm_i) disable iff (rst_i)
      pop_i |-> !empty_o
   );

   a_no_push_full: assert property (
      @(posedge clkcomm_i) disable iff (rst_i)
      do_push |-> (level != sysele_pkg::FIFO_DEPTH)
   );

endmodule

//--- dac_unpacker.sv
// One DAC pair per clock from buffered words; led_o follows dac_o one cycle late, DIP decoded each cycle
`timescale 1ns/1ps

module dac_unpacker (
   input  logic                            clkcomm_i,
   input  logic                            rst_i,
   input  logic                            flush_i,
   input  logic [sysele_pkg::WORD_W-1:0]   rd_data_i,
   input  logic                            empty_i,
   input  logic [7:0]                      dip_i,
   output logic                            pop_o,
   output sysele_pkg::dac_pair_t           dac_o,
   output logic                            dac_valid_o,
   output logic [7:0]                      led_o
);

   sysele_pkg::player_state_e                        state;
   logic [sysele_pkg::WORD_W-1:0]                    word_q;
   // Next pair to emit from word_q, zero once the word is drained
   logic [$clog2(sysele_pkg::PAIRS_PER_WORD)-1:0]    idx;
   logic                                             take;
   sysele_pkg::led_sel_e                             led_sel;

   // DA1 in the low half of each 12-bit pair
   function automatic sysele_pkg::dac_pair_t pick_pair(
      input logic [sysele_pkg::WORD_W-1:0]                 word,
      input logic [$clog2(sysele_pkg::PAIRS_PER_WORD)-1:0] sel
   );
      sysele_pkg::dac_pair_t            pair;
      logic [2*sysele_pkg::CODE_W-1:0]  slice;
      slice    = word[sel * 2 * sysele_pkg::CODE_W +: 2 * sysele_pkg::CODE_W];
      pair.da1 = slice[sysele_pkg::CODE_W-1:0];
      pair.da2 = slice[2*sysele_pkg::CODE_W-1:sysele_pkg::CODE_W];
      return pair;
   endfunction

   // --------------------------------------------------
   // Word fetch
   // --------------------------------------------------
   // Take a head word when idle or when the current one is used up
   assign take  = !flush_i && !empty_i &&
                  ((state == sysele_pkg::PL_IDLE) || (idx == '0));
   assign pop_o = take;

   always_ff @(posedge clkcomm_i) begin
      if (take) begin
         word_q <= rd_data_i;
      end
   end

   // --------------------------------------------------
   // Player FSM
   // --------------------------------------------------
   always_ff @(posedge clkcomm_i) begin
      if (rst_i || flush_i) begin
         state       <= sysele_pkg::PL_IDLE;
         idx         <= '0;
         dac_o       <= '0;
         dac_valid_o <= 1'b0;
      end else if (take) begin
         // Pair 0 straight from the head so words follow without a gap
         state       <= sysele_pkg::PL_PLAY;
         idx         <= 1'b1;
         dac_o       <= pick_pair(rd_data_i, '0);
         dac_valid_o <= 1'b1;
      end else if ((state == sysele_pkg::PL_PLAY) && (idx != '0)) begin
         idx   <= idx + 1'b1;
         dac_o <= pick_pair(word_q, idx);
      end else begin
         // Starved, wait for the next word
         state       <= sysele_pkg::PL_IDLE;
         dac_o       <= '0;
         dac_valid_o <= 1'b0;
      end
   end

   // --------------------------------------------------
   // LED debug view
   // --------------------------------------------------
   assign led_sel = sysele_pkg::led_sel_e'(dip_i);

   always_ff @(posedge clkcomm_i) begin
      if (rst_i) begin
         led_o <= 8'h00;
      end else begin
         case (led_sel)
            sysele_pkg::LED_DA1: led_o <= {{(8 - sysele_pkg::CODE_W){1'b0}}, dac_o.da1};
            sysele_pkg::LED_DA2: led_o <= {{(8 - sysele_pkg::CODE_W){1'b0}}, dac_o.da2};
            default:             led_o <= 8'h00;
         endcase
      end
   end

endmodule

//--- sysele_dac_top.sv
// Single clock playback path; start_i and stop_i are one-cycle pulses, latency to dac_valid_o varies
`timescale 1ns/1ps

module sysele_dac_top (
   input  logic                   clkcomm_i,
   input  logic                   rst_i,
   input  sysele_pkg::mem_wr_t    load_i,
   input  logic                   start_i,
   input  logic                   stop_i,
   input  logic [7:0]             dip_i,
   output sysele_pkg::dac_pair_t  dac_o,
   output logic                   dac_valid_o,
   output logic [7:0]             led_o
);

   // --------------------------------------------------
   // Internal wires
   // --------------------------------------------------
   sysele_pkg::fifo_push_t             push;
   logic [sysele_pkg::LEVEL_W-1:0]     fifo_level;
   logic [sysele_pkg::WORD_W-1:0]      fifo_data;
   logic                               fifo_empty;
   logic                               fifo_pop;

   // Producer
   sample_reader i_reader (
      .clkcomm_i (clkcomm_i),
      .rst_i     (rst_i),
      .load_i    (load_i),
      .start_i   (start_i),
      .stop_i    (stop_i),
      .level_i   (fifo_level),
      .push_o    (push)
   );

   // Buffer
   sample_fifo i_fifo (
      .clkcomm_i (clkcomm_i),
      .rst_i     (rst_i),
      .push_i    (push),
      .pop_i     (fifo_pop),
      .rd_data_o (fifo_data),
      .empty_o   (fifo_empty),
      .level_o   (fifo_level)
   );

   // Consumer, shares the reader flush with the FIFO
   dac_unpacker i_unpacker (
      .clkcomm_i   (clkcomm_i),
      .rst_i       (rst_i),
      .flush_i     (push.flush),
      .rd_data_i   (fifo_data),
      .empty_i     (fifo_empty),
      .dip_i       (dip_i),
      .pop_o       (fifo_pop),
      .dac_o       (dac_o),
      .dac_valid_o (dac_valid_o),
      .led_o       (led_o)
   );

endmodule

//--- tb_clock.sv
// Free-running 20 ns clock from time zero; reset is released on the falling edge after two rising edges
`timescale 1ns/1ps

module tb_clock (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #10 clk_o = ~clk_o;
      end
   end

   // Reset held for two cycles, released on a falling edge
   initial begin
      rst_o = 1'b1;
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

//--- tb_sysele.sv
// Reads sysele_vectors.txt from the working directory; inputs driven and outputs sampled on falling edges
`timescale 1ns/1ps

module tb_sysele;

   localparam int WAIT_LIMIT   = 2000;
   localparam int QUIET_CYCLES = 20;
   localparam int PLAY_PAIRS   = 300;
   localparam int MEM_WORDS    = 64;

   logic                    clk;
   logic                    rst;
   sysele_pkg::mem_wr_t     load;
   logic                    start;
   logic                    stop;
   logic [7:0]              dip;
   sysele_pkg::dac_pair_t   dac;
   logic                    dac_valid;
   logic [7:0]              led;

   logic [sysele_pkg::WORD_W-1:0] words [MEM_WORDS];
   sysele_pkg::dac_pair_t         first_pairs [$];
   logic [7:0]                    led_dip [$];
   logic [7:0]                    led_exp [$];
   int                            words_loaded;
   int                            pair_errors;
   int                            led_errors;
   int                            other_errors;
   int                            timeout_errors;
   logic                          aborted;
   integer                        seed;

   tb_clock i_clock (
      .clk_o (clk),
      .rst_o (rst)
   );

   sysele_dac_top i_dut (
      .clkcomm_i   (clk),
      .rst_i       (rst),
      .load_i      (load),
      .start_i     (start),
      .stop_i      (stop),
      .dip_i       (dip),
      .dac_o       (dac),
      .dac_valid_o (dac_valid),
      .led_o       (led)
   );

   // --------------------------------------------------
   // Reference model of the word layout
   // --------------------------------------------------
   // Pair p sits at bits 12p+11..12p, DA1 in its low six bits
   function automatic sysele_pkg::dac_pair_t pair_of(input logic [47:0] word, input int p);
      logic [11:0]           bits;
      sysele_pkg::dac_pair_t pr;
      bits   = word[p*12 +: 12];
      pr.da1 = bits[5:0];
      pr.da2 = bits[11:6];
      return pr;
   endfunction

   function automatic int const_word_addr();
      for (int a = 0; a < MEM_WORDS; a++) begin
         if ((words[a][11:0] == words[a][23:12]) && (words[a][11:0] == words[a][35:24]) &&
             (words[a][11:0] == words[a][47:36])) begin
            return a;
         end
      end
      return -1;
   endfunction

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_pair(input string name, input sysele_pkg::dac_pair_t exp,
                             input sysele_pkg::dac_pair_t act);
      if (act !== exp) begin
         pair_errors++;
         $display("error at %0t ns: %s expected da1=%h da2=%h, actual da1=%h da2=%h",
                  $time, name, exp.da1, exp.da2, act.da1, act.da2);
      end
   endtask

   task automatic check_led(input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp) begin
         led_errors++;
         $display("error at %0t ns: led_o expected %h, actual %h", $time, exp, act);
      end
   endtask

   task automatic report_timeout(input string what);
      timeout_errors++;
      aborted = 1'b1;
      $display("Timeout at %0t ns while %s", $time, what);
   endtask

   // --------------------------------------------------
   // Vector file
   // --------------------------------------------------
   task automatic read_vectors();
      int                    fd;
      int                    code;
      string                 kind;
      string                 rest;
      logic [47:0]           a;
      logic [47:0]           b;
      sysele_pkg::dac_pair_t pr;
      fd = $fopen("sysele_vectors.txt", "r");
      if (fd == 0) begin
         other_errors++;
         aborted = 1'b1;
         $display("Could not open sysele_vectors.txt");
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %s", kind);
         if (code != 1) begin
            break;
         end
         // Comments and section markers carry no data
         if ((kind == "//") || (kind == "S")) begin
            code = $fgets(rest, fd);
         end else begin
            code = $fscanf(fd, " %h %h", a, b);
            if (kind == "L") begin
               words[a[5:0]] = b;
               words_loaded++;
            end else if (kind == "P") begin
               pr.da1 = a[5:0];
               pr.da2 = b[5:0];
               first_pairs.push_back(pr);
            end else if (kind == "D") begin
               led_dip.push_back(a[7:0]);
               led_exp.push_back(b[7:0]);
            end
         end
      end
      $fclose(fd);
      if ((words_loaded != MEM_WORDS) || (first_pairs.size() == 0) || (led_dip.size() == 0)) begin
         other_errors++;
         aborted = 1'b1;
         $display("Vector file is incomplete, %0d load lines found", words_loaded);
      end
   endtask

   // --------------------------------------------------
   // Stimulus helpers
   // --------------------------------------------------
   task automatic send_start();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic send_stop();
      stop = 1'b1;
      @(negedge clk);
      stop = 1'b0;
   endtask

   task automatic load_memory();
      for (int a = 0; a < MEM_WORDS; a++) begin
         load.en   = 1'b1;
         load.addr = a[5:0];
         load.data = words[a];
         @(negedge clk);
      end
      load = '0;
   endtask

   task automatic wait_valid(input string what);
      int n;
      n = 0;
      while ((dac_valid !== 1'b1) && (n < WAIT_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (dac_valid !== 1'b1) begin
         report_timeout(what);
      end
   endtask

   // Output must rest at zero with no valid
   task automatic check_quiet(input string phase);
      repeat (QUIET_CYCLES) begin
         if (dac_valid !== 1'b0) begin
            other_errors++;
            $display("error at %0t ns: dac_valid_o %s expected 0, actual %b",
                     $time, phase, dac_valid);
         end
         check_pair("dac_o", '0, dac);
         @(negedge clk);
      end
   endtask

   // --------------------------------------------------
   // Behaviors
   // --------------------------------------------------
   task automatic check_playback();
      int                    k;
      int                    idle;
      int                    target;
      sysele_pkg::dac_pair_t exp;
      // Random extra pairs before the stop pulse
      target = PLAY_PAIRS + ($unsigned($random(seed)) % 16);
      send_start();
      wait_valid("waiting for the first pair after start");
      if (aborted) begin
         return;
      end
      k    = 0;
      idle = 0;
      while ((k < target) && (idle < WAIT_LIMIT)) begin
         if (dac_valid === 1'b1) begin
            exp = pair_of(words[(k / 4) % MEM_WORDS], k % 4);
            check_pair("dac_o", exp, dac);
            k++;
            idle = 0;
         end else begin
            idle++;
         end
         @(negedge clk);
      end
      if (k < target) begin
         report_timeout("playback stalled");
      end
   endtask

   task automatic check_stop();
      int n;
      send_stop();
      n = 1;
      while ((dac_valid !== 1'b0) && (n < 2)) begin
         @(negedge clk);
         n++;
      end
      if (dac_valid !== 1'b0) begin
         other_errors++;
         $display("error at %0t ns: dac_valid_o two cycles after stop expected 0, actual %b",
                  $time, dac_valid);
      end
      check_quiet("after stop");
   endtask

   task automatic check_restart();
      send_start();
      wait_valid("waiting for the first pair after restart");
      if (aborted) begin
         return;
      end
      for (int i = 0; i < first_pairs.size(); i++) begin
         if (dac_valid !== 1'b1) begin
            other_errors++;
            $display("error at %0t ns: dac_valid_o in first word after restart expected 1, actual %b",
                     $time, dac_valid);
         end
         check_pair("dac_o", first_pairs[i], dac);
         @(negedge clk);
      end
   endtask

   task automatic check_leds();
      int                    addr;
      int                    n;
      sysele_pkg::dac_pair_t target;
      sysele_pkg::dac_pair_t prev;
      addr = const_word_addr();
      if (addr < 0) begin
         other_errors++;
         $display("No constant-code word found in the vector file");
         return;
      end
      target = pair_of(words[addr], 0);
      n      = 0;
      while (!((dac_valid === 1'b1) && (dac === target)) && (n < WAIT_LIMIT)) begin
         @(negedge clk);
         n++;
      end
      if (!((dac_valid === 1'b1) && (dac === target))) begin
         report_timeout("waiting for the constant-code segment");
         return;
      end
      for (int i = 0; i < led_dip.size(); i++) begin
         dip  = led_dip[i];
         prev = dac;
         @(negedge clk);
         if (prev !== target) begin
            other_errors++;
            $display("Playback left the constant-code segment during the LED checks");
         end
         check_led(led_exp[i], led);
      end
      dip = 8'h00;
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      int n;
      load           = '0;
      start          = 1'b0;
      stop           = 1'b0;
      dip            = 8'h00;
      seed           = 32'hafff;
      words_loaded   = 0;
      pair_errors    = 0;
      led_errors     = 0;
      other_errors   = 0;
      timeout_errors = 0;
      aborted        = 1'b0;
      read_vectors();
      n = 0;
      while ((rst !== 1'b0) && (n < 10)) begin
         @(negedge clk);
         n++;
      end
      if (rst !== 1'b0) begin
         report_timeout("waiting for reset release");
      end
      if (!aborted) begin
         check_quiet("before start");
         load_memory();
         check_playback();
      end
      if (!aborted) begin
         check_stop();
         check_restart();
      end
      if (!aborted) begin
         check_leds();
      end
      $display("Errors: pair %0d, led %0d, other %0d, timeout %0d",
               pair_errors, led_errors, other_errors, timeout_errors);
      if ((pair_errors + led_errors + other_errors + timeout_errors) == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- sysele_vectors.txt
// L addr word : load one 48-bit sample word, P da1 da2 : expected pairs after a start
// D dip led : DIP value and expected LED, S name : section marker, all numbers in hex
S load
L 00 8C0480240100
L 01 8C1481241101
L 02 8C2482242102
L 03 8C3483243103
L 04 8C4484244104
L 05 8C5485245105
L 06 8C6486246106
L 07 8C7487247107
L 08 8C8488248108
L 09 8C9489249109
L 0A 8CA48A24A10A
L 0B 8CB48B24B10B
L 0C 8CC48C24C10C
L 0D 8CD48D24D10D
L 0E 8CE48E24E10E
L 0F 8CF48F24F10F
L 10 8D0490250110
L 11 8D1491251111
L 12 8D2492252112
L 13 8D3493253113
L 14 8D4494254114
L 15 8D5495255115
L 16 8D6496256116
L 17 8D7497257117
L 18 8D8498258118
L 19 8D9499259119
L 1A 8DA49A25A11A
L 1B 8DB49B25B11B
L 1C 8DC49C25C11C
L 1D 8DD49D25D11D
L 1E 8DE49E25E11E
L 1F 8DF49F25F11F
L 20 A95A95A95A95
L 21 A95A95A95A95
L 22 A95A95A95A95
L 23 A95A95A95A95
L 24 A95A95A95A95
L 25 A95A95A95A95
L 26 A95A95A95A95
L 27 A95A95A95A95
L 28 A95A95A95A95
L 29 A95A95A95A95
L 2A A95A95A95A95
L 2B A95A95A95A95
L 2C A95A95A95A95
L 2D A95A95A95A95
L 2E A95A95A95A95
L 2F A95A95A95A95
L 30 8F04B0270130
L 31 8F14B1271131
L 32 8F24B2272132
L 33 8F34B3273133
L 34 8F44B4274134
L 35 8F54B5275135
L 36 8F64B6276136
L 37 8F74B7277137
L 38 8F84B8278138
L 39 8F94B9279139
L 3A 8FA4BA27A13A
L 3B 8FB4BB27B13B
L 3C 8FC4BC27C13C
L 3D 8FD4BD27D13D
L 3E 8FE4BE27E13E
L 3F 8FF4BF27F13F
S pairs
P 00 04
P 00 09
P 00 12
P 00 23
S led
D 83 15
D 84 2A
D 5A 00

//--- tb.f
sysele_pkg.sv
sample_reader.sv
sample_fifo.sv
dac_unpacker.sv
sysele_dac_top.sv
tb_clock.sv
tb_sysele.sv

//--- Bender.yml
package:
  name: sysele_dac

sources:
  - sysele_pkg.sv
  - sample_reader.sv
  - sample_fifo.sv
  - dac_unpacker.sv
  - sysele_dac_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_sysele.sv
